// ==== list.f ====
+incdir+logic
logic/rename_pkg.sv
logic/free_list.sv
logic/checkpoint_store.sv
logic/map_table.sv
logic/rename_stage.sv
dv/rename_model.sv
dv/rename_tb.sv

// ==== Makefile ====
SOURCES := list.f $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: build run clean

build: obj_dir/Vrename_tb

obj_dir/Vrename_tb: $(SOURCES)
	verilator --binary --assert -f list.f --top-module rename_tb

run: obj_dir/Vrename_tb
	./obj_dir/Vrename_tb

clean:
	rm -rf obj_dir

// ==== dv/rename_tb.sv ====
/*
 * Testbench of the rename stage
 * Random groups, checkpoints, recoveries and legal releases against the model
 */
`include "rename_params.svh"

module rename_tb;

  import rename_pkg::*;

  localparam int RUN_CYCLES  = 2000;
  localparam int STALL_LIMIT = 500;

  logic                           clock;
  logic                           reset;
  logic                           rename_valid;
  group_mask_t                    rd_valid;
  arf_index_t [`RENAME_WIDTH-1:0] rs1;
  arf_index_t [`RENAME_WIDTH-1:0] rs2;
  arf_index_t [`RENAME_WIDTH-1:0] rd;
  logic                           check;
  cp_index_t                      check_idx;
  logic                           recover;
  cp_index_t                      recover_idx;
  group_mask_t                    release_valid;
  prf_index_t [`RENAME_WIDTH-1:0] release_prf;
  prf_index_t [`RENAME_WIDTH-1:0] prs1;
  prf_index_t [`RENAME_WIDTH-1:0] prs2;
  prf_index_t [`RENAME_WIDTH-1:0] prd;
  prf_index_t [`RENAME_WIDTH-1:0] prev_rd;
  logic                           allocatable;
  prf_mask_t                      release_ok;
  logic                           mismatch;
  int                             cycles;

  rename_stage i_dut (
    .clock         (clock),
    .reset         (reset),
    .rename_valid  (rename_valid),
    .rd_valid      (rd_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .check         (check),
    .check_idx     (check_idx),
    .recover       (recover),
    .recover_idx   (recover_idx),
    .release_valid (release_valid),
    .release_prf   (release_prf),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .allocatable   (allocatable)
  );

  rename_model i_model (
    .clock         (clock),
    .reset         (reset),
    .rename_valid  (rename_valid),
    .rd_valid      (rd_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .check         (check),
    .check_idx     (check_idx),
    .recover       (recover),
    .recover_idx   (recover_idx),
    .release_valid (release_valid),
    .release_prf   (release_prf),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .allocatable   (allocatable),
    .release_ok    (release_ok),
    .mismatch      (mismatch)
  );

  always #10 clock = ~clock;

  always @(posedge mismatch) begin
    $display(">>> FAIL");
    $fatal(1, "reference model check failed at time %0t", $time);
  end

  task automatic clear_sideband();
    check         = 1'b0;
    check_idx     = '0;
    recover       = 1'b0;
    recover_idx   = '0;
    release_valid = '0;
    release_prf   = '0;
  endtask

  // First group after reset takes two destinations
  task automatic draw_group(input logic first);
    rename_valid = first || ($urandom_range(0, 3) != 0);
    rd_valid     = first ? '1 : group_mask_t'($urandom_range(0, 3));
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      rs1[i] = arf_index_t'($urandom_range(0, `ARF_SIZE - 1));
      rs2[i] = arf_index_t'($urandom_range(0, `ARF_SIZE - 1));
      rd[i]  = arf_index_t'($urandom_range(0, `ARF_SIZE - 1));
    end
  endtask

  task automatic draw_sideband();
    prf_mask_t taken;
    int        start;
    int        p;
    clear_sideband();
    taken       = '0;
    check       = ($urandom_range(0, 7) == 0);
    check_idx   = cp_index_t'($urandom_range(0, `CP_COUNT - 1));
    recover     = ($urandom_range(0, 15) == 0);
    recover_idx = cp_index_t'($urandom_range(0, `CP_COUNT - 1));
    if (check && recover && check_idx == recover_idx) begin
      check = 1'b0;
    end
    // Releases only from dead registers that no snapshot still names
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if ($urandom_range(0, 1) == 1) begin
        start = int'($urandom_range(0, `PRF_SIZE - 1));
        for (int n = 0; n < `PRF_SIZE; n++) begin
          p = (start + n) % `PRF_SIZE;
          if (!release_valid[i] && release_ok[p] && !taken[p]) begin
            release_valid[i] = 1'b1;
            release_prf[i]   = prf_index_t'(p);
            taken[p]         = 1'b1;
          end
        end
      end
    end
  endtask

  initial begin
    int waited;
    void'($urandom(95));
    clock        = 1'b0;
    reset        = 1'b1;
    rename_valid = 1'b0;
    rd_valid     = '0;
    rs1          = '0;
    rs2          = '0;
    rd           = '0;
    clear_sideband();
    cycles = 0;
    repeat (16) @(posedge clock);
    #2;
    reset = 1'b0;
    draw_group(1'b1);
    while (cycles < RUN_CYCLES) begin
      waited = 0;
      // Hold a stalled group until registers come back
      while (rename_valid && !allocatable) begin
        if (waited == STALL_LIMIT) begin
          $display("group stalled for %0d cycles with no free registers", waited);
          $display(">>> FAIL");
          $fatal(1, "stall timeout");
        end
        @(posedge clock);
        #2;
        draw_sideband();
        waited++;
        cycles++;
      end
      @(posedge clock);
      #2;
      cycles++;
      draw_group(1'b0);
      draw_sideband();
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== dv/rename_model.sv ====
/*
 * Reference model of the rename map, free bitmap and checkpoint slots
 * Immediate assertions compare the stage outputs with it
 */
`include "rename_params.svh"

module rename_model (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       rename_valid,
  input  rename_pkg::group_mask_t                    rd_valid,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rs1,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rs2,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rd,
  input  logic                                       check,
  input  rename_pkg::cp_index_t                      check_idx,
  input  logic                                       recover,
  input  rename_pkg::cp_index_t                      recover_idx,
  input  rename_pkg::group_mask_t                    release_valid,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] release_prf,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prs1,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prs2,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prd,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prev_rd,
  input  logic                                       allocatable,
  output rename_pkg::prf_mask_t                      release_ok,
  output logic                                       mismatch
);

  import rename_pkg::*;

  prf_index_t map_m [`ARF_SIZE];
  prf_index_t cp_map [`CP_COUNT][`ARF_SIZE];
  prf_mask_t  free_m;
  prf_mask_t  cp_free [`CP_COUNT];
  prf_mask_t  recycled;
  prf_index_t dead_q [$];
  logic       fresh;
  logic       restored;

  prf_index_t work_map [`ARF_SIZE];
  prf_mask_t  work_free;
  prf_index_t exp_prs1 [`RENAME_WIDTH];
  prf_index_t exp_prs2 [`RENAME_WIDTH];
  prf_index_t exp_prd [`RENAME_WIDTH];
  prf_index_t exp_prev [`RENAME_WIDTH];
  logic       exp_alloc;

  function automatic logic holds_register(input prf_index_t table_in [`ARF_SIZE],
                                          input prf_index_t p);
    for (int a = 0; a < `ARF_SIZE; a++) begin
      if (table_in[a] == p) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic flag_mismatch(input string name, input int expected, input int actual);
    $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
    mismatch = 1'b1;
  endtask

  ////////////////////
  // Expected group

  // Lowest free register per slot with earlier destinations seen by later slots
  always_comb begin
    work_map  = map_m;
    work_free = free_m;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      exp_prs1[i] = work_map[rs1[i]];
      exp_prs2[i] = work_map[rs2[i]];
      exp_prev[i] = work_map[rd[i]];
      exp_prd[i]  = '0;
      for (int p = `PRF_SIZE - 1; p >= 0; p--) begin
        if (work_free[p]) begin
          exp_prd[i] = prf_index_t'(p);
        end
      end
      if (rd_valid[i]) begin
        work_map[rd[i]]       = exp_prd[i];
        work_free[exp_prd[i]] = 1'b0;
      end
    end
    exp_alloc = ($countones(free_m) >= `RENAME_WIDTH);
  end

  ////////////////////
  // State update

  always @(posedge clock) begin : update_model
    prf_index_t new_map [`ARF_SIZE];
    prf_mask_t  new_free;
    prf_mask_t  rel_bits;
    prf_mask_t  ok_bits;
    logic       fire;
    if (reset) begin
      for (int a = 0; a < `ARF_SIZE; a++) begin
        new_map[a] = prf_index_t'(a);
      end
      for (int p = 0; p < `PRF_SIZE; p++) begin
        new_free[p] = (p >= `ARF_SIZE);
      end
      for (int c = 0; c < `CP_COUNT; c++) begin
        cp_map[c]  <= new_map;
        cp_free[c] <= new_free;
      end
      map_m      <= new_map;
      free_m     <= new_free;
      recycled   <= '0;
      release_ok <= '0;
      fresh      <= 1'b1;
      restored   <= 1'b0;
      dead_q.delete();
    end else begin
      rel_bits = '0;
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        if (release_valid[i]) begin
          rel_bits[release_prf[i]] = 1'b1;
        end
      end
      fire = rename_valid && exp_alloc && !recover;
      if (recover) begin
        new_map  = cp_map[recover_idx];
        new_free = cp_free[recover_idx] | rel_bits;
      end else if (fire) begin
        new_map  = work_map;
        new_free = work_free | rel_bits;
      end else begin
        new_map  = map_m;
        new_free = free_m | rel_bits;
      end
      // Dead registers are neither free nor mapped
      if (recover) begin
        dead_q.delete();
        for (int p = 0; p < `PRF_SIZE; p++) begin
          if (!new_free[p] && !holds_register(new_map, prf_index_t'(p))) begin
            dead_q.push_back(prf_index_t'(p));
          end
        end
      end else begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
          if (fire && rd_valid[i]) begin
            dead_q.push_back(exp_prev[i]);
          end
        end
        for (int k = dead_q.size() - 1; k >= 0; k--) begin
          if (rel_bits[dead_q[k]]) begin
            dead_q.delete(k);
          end
        end
      end
      ok_bits = '0;
      foreach (dead_q[k]) begin
        ok_bits[dead_q[k]] = 1'b1;
      end
      for (int c = 0; c < `CP_COUNT; c++) begin
        for (int a = 0; a < `ARF_SIZE; a++) begin
          // A register still named by any snapshot stays held
          if (check && int'(check_idx) == c) begin
            ok_bits[new_map[a]] = 1'b0;
          end else begin
            ok_bits[cp_map[c][a]] = 1'b0;
          end
        end
        if (check && int'(check_idx) == c) begin
          cp_map[c]  <= new_map;
          cp_free[c] <= new_free;
        end else begin
          cp_free[c] <= cp_free[c] | rel_bits;
        end
      end
      map_m      <= new_map;
      free_m     <= new_free;
      recycled   <= recycled | rel_bits;
      release_ok <= ok_bits;
      restored   <= recover;
      if (fire) begin
        fresh <= 1'b0;
      end
    end
  end

  ////////////////////
  // Output checks

  always @(negedge clock) begin : check_outputs
    string src_name;
    string dst_name;
    src_name = fresh ? "reset_state" : (restored ? "recover" : "rename_sources");
    if (reset) begin
      mismatch = 1'b0;
    end else begin
      assert (allocatable == exp_alloc)
        else flag_mismatch("stall", int'(exp_alloc), int'(allocatable));
      for (int i = 0; i < `RENAME_WIDTH; i++) begin
        dst_name = fresh ? "reset_state" : (recycled[exp_prd[i]] ? "release" : "rename_dest");
        if (rename_valid) begin
          assert (prs1[i] == exp_prs1[i])
            else flag_mismatch(src_name, int'(exp_prs1[i]), int'(prs1[i]));
          assert (prs2[i] == exp_prs2[i])
            else flag_mismatch(src_name, int'(exp_prs2[i]), int'(prs2[i]));
        end
        if (rename_valid && exp_alloc && rd_valid[i]) begin
          assert (prd[i] == exp_prd[i])
            else flag_mismatch(dst_name, int'(exp_prd[i]), int'(prd[i]));
          assert (prev_rd[i] == exp_prev[i])
            else flag_mismatch(dst_name, int'(exp_prev[i]), int'(prev_rd[i]));
        end
      end
    end
  end

endmodule

// ==== logic/rename_stage.sv ====
/*
 * Integer rename stage top joining map table, free list and checkpoints
 */
`include "rename_params.svh"

module rename_stage (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       rename_valid,
  input  rename_pkg::group_mask_t                    rd_valid,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rs1,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rs2,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rd,
  input  logic                                       check,
  input  rename_pkg::cp_index_t                      check_idx,
  input  logic                                       recover,
  input  rename_pkg::cp_index_t                      recover_idx,
  input  rename_pkg::group_mask_t                    release_valid,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] release_prf,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prs1,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prs2,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prd,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prev_rd,
  output logic                                       allocatable
);

  import rename_pkg::*;

  prf_index_t [`RENAME_WIDTH-1:0] alloc_prf;
  group_mask_t                    alloc_take;
  logic                           rename_fire;
  prf_index_t [`ARF_SIZE-1:0]     map_snapshot;
  prf_index_t [`ARF_SIZE-1:0]     map_restore;
  prf_mask_t                      free_snapshot;
  prf_mask_t                      free_restore;

  // Only slots of a firing group take a register
  assign alloc_take = rd_valid & {`RENAME_WIDTH{rename_fire}};

  map_table i_map_table (
    .clock        (clock),
    .reset        (reset),
    .recover      (recover),
    .rename_valid (rename_valid),
    .allocatable  (allocatable),
    .rd_valid     (rd_valid),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .alloc_prf    (alloc_prf),
    .map_restore  (map_restore),
    .rename_fire  (rename_fire),
    .prs1         (prs1),
    .prs2         (prs2),
    .prd          (prd),
    .prev_rd      (prev_rd),
    .map_snapshot (map_snapshot)
  );

  free_list i_free_list (
    .clock         (clock),
    .reset         (reset),
    .recover       (recover),
    .alloc_take    (alloc_take),
    .release_valid (release_valid),
    .release_prf   (release_prf),
    .free_restore  (free_restore),
    .alloc_prf     (alloc_prf),
    .allocatable   (allocatable),
    .free_snapshot (free_snapshot)
  );

  checkpoint_store i_checkpoint_store (
    .clock         (clock),
    .reset         (reset),
    .check         (check),
    .check_idx     (check_idx),
    .recover       (recover),
    .recover_idx   (recover_idx),
    .map_snapshot  (map_snapshot),
    .free_snapshot (free_snapshot),
    .release_valid (release_valid),
    .release_prf   (release_prf),
    .map_restore   (map_restore),
    .free_restore  (free_restore)
  );

endmodule

// ==== logic/map_table.sv ====
/*
 * Architectural to physical map table
 * Group rename with in-group bypass, previous mapping lookup and restore
 */
`include "rename_params.svh"

module map_table (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       recover,
  input  logic                                       rename_valid,
  input  logic                                       allocatable,
  input  rename_pkg::group_mask_t                    rd_valid,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rs1,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rs2,
  input  rename_pkg::arf_index_t [`RENAME_WIDTH-1:0] rd,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] alloc_prf,
  input  rename_pkg::prf_index_t [`ARF_SIZE-1:0]     map_restore,
  output logic                                       rename_fire,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prs1,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prs2,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prd,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] prev_rd,
  output rename_pkg::prf_index_t [`ARF_SIZE-1:0]     map_snapshot
);

  import rename_pkg::*;

  prf_index_t [`ARF_SIZE-1:0] map_q;
  prf_index_t [`ARF_SIZE-1:0] map_work;
  prf_index_t [`ARF_SIZE-1:0] map_next;
  group_mask_t                prd_mapped;

  // Group advances only with a full set of free registers
  assign rename_fire = rename_valid & allocatable;

  ////////////////////
  // Group rename

  // Slots walk in order over a working copy, so later slots see earlier writes
  always_comb begin
    int next_alloc;
    next_alloc = 0;
    map_work   = map_q;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      prs1[i]    = map_work[rs1[i]];
      prs2[i]    = map_work[rs2[i]];
      prev_rd[i] = map_work[rd[i]];
      prd[i]     = alloc_prf[next_alloc];
      if (rd_valid[i]) begin
        map_work[rd[i]] = alloc_prf[next_alloc];
        next_alloc      = next_alloc + 1;
      end
    end
  end

  ////////////////////
  // Table update

  // Recovery wins over the group
  always_comb begin
    if (recover) begin
      map_next = map_restore;
    end else if (rename_fire) begin
      map_next = map_work;
    end else begin
      map_next = map_q;
    end
  end

  // A check stores the table as it will be after this edge
  assign map_snapshot = map_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < `ARF_SIZE; a++) begin
        map_q[a] <= prf_index_t'(a);
      end
    end else begin
      map_q <= map_next;
    end
  end

  // Whether a new destination is still named somewhere in the table
  always_comb begin
    prd_mapped = '0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      for (int a = 0; a < `ARF_SIZE; a++) begin
        if (map_q[a] == prd[i]) begin
          prd_mapped[i] = 1'b1;
        end
      end
    end
  end

  // Free list and table must never disagree on a handed-out register
  for (genvar i = 0; i < `RENAME_WIDTH; i++) begin : g_prd_check
    a_prd_unmapped : assert property (@(posedge clock) disable iff (reset)
      rename_fire && rd_valid[i] |-> !prd_mapped[i])
      else $error("slot %0d got register %0d which is still mapped", i, prd[i]);
  end

endmodule

// ==== logic/checkpoint_store.sv ====
/*
 * Checkpoint slots holding map table and free bitmap snapshots
 * Commit releases are folded into every stored bitmap
 */
`include "rename_params.svh"

module checkpoint_store (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       check,
  input  rename_pkg::cp_index_t                      check_idx,
  input  logic                                       recover,
  input  rename_pkg::cp_index_t                      recover_idx,
  input  rename_pkg::prf_index_t [`ARF_SIZE-1:0]     map_snapshot,
  input  rename_pkg::prf_mask_t                      free_snapshot,
  input  rename_pkg::group_mask_t                    release_valid,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] release_prf,
  output rename_pkg::prf_index_t [`ARF_SIZE-1:0]     map_restore,
  output rename_pkg::prf_mask_t                      free_restore
);

  import rename_pkg::*;

  prf_index_t [`ARF_SIZE-1:0] map_slot [`CP_COUNT];
  prf_mask_t                  free_slot [`CP_COUNT];
  prf_mask_t                  release_mask;

  assign release_mask = release_mask_of(release_valid, release_prf);

  // The slot being written already sees this cycle's releases via free_snapshot
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int c = 0; c < `CP_COUNT; c++) begin
        for (int a = 0; a < `ARF_SIZE; a++) begin
          map_slot[c][a] <= prf_index_t'(a);
        end
        free_slot[c] <= RESET_FREE;
      end
    end else begin
      for (int c = 0; c < `CP_COUNT; c++) begin
        if (check && check_idx == cp_index_t'(c)) begin
          map_slot[c]  <= map_snapshot;
          free_slot[c] <= free_snapshot;
        end else begin
          free_slot[c] <= free_slot[c] | release_mask;
        end
      end
    end
  end

  // Restore path read directly for a one cycle recovery
  assign map_restore  = map_slot[recover_idx];
  assign free_restore = free_slot[recover_idx];

  // Restoring a slot while overwriting it would mix two states
  a_check_recover_apart : assert property (@(posedge clock) disable iff (reset)
    check && recover |-> check_idx != recover_idx)
    else $error("check and recover both on slot %0d", check_idx);

endmodule

// ==== logic/free_list.sv ====
/*
 * Free physical register bitmap
 * Lowest-first allocation search, commit release and checkpoint restore
 */
`include "rename_params.svh"

module free_list (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       recover,
  input  rename_pkg::group_mask_t                    alloc_take,
  input  rename_pkg::group_mask_t                    release_valid,
  input  rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] release_prf,
  input  rename_pkg::prf_mask_t                      free_restore,
  output rename_pkg::prf_index_t [`RENAME_WIDTH-1:0] alloc_prf,
  output logic                                       allocatable,
  output rename_pkg::prf_mask_t                      free_snapshot
);

  import rename_pkg::*;

  prf_mask_t   free_q;
  prf_mask_t   free_next;
  prf_mask_t   search_mask;
  prf_mask_t   take_mask;
  prf_mask_t   release_mask;
  group_mask_t cand_found;

  ////////////////////
  // Allocation search

  // Candidate k is the k-th lowest free register
  always_comb begin
    search_mask = free_q;
    for (int k = 0; k < `RENAME_WIDTH; k++) begin
      cand_found[k] = 1'b0;
      alloc_prf[k]  = '0;
      for (int b = 0; b < `PRF_SIZE; b++) begin
        if (search_mask[b] && !cand_found[k]) begin
          cand_found[k] = 1'b1;
          alloc_prf[k]  = prf_index_t'(b);
        end
      end
      if (cand_found[k]) begin
        search_mask[alloc_prf[k]] = 1'b0;
      end
    end
  end

  // Enough free registers for a full group
  assign allocatable = cand_found[`RENAME_WIDTH-1];

  // Valid slots consume candidates in order, so only the count matters
  always_comb begin
    int taken;
    taken     = 0;
    take_mask = '0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (alloc_take[i]) begin
        take_mask[alloc_prf[taken]] = 1'b1;
        taken = taken + 1;
      end
    end
  end

  ////////////////////
  // Next bitmap

  assign release_mask = release_mask_of(release_valid, release_prf);

  // Releases still land on a restored bitmap
  always_comb begin
    if (recover) begin
      free_next = free_restore | release_mask;
    end else begin
      free_next = (free_q & ~take_mask) | release_mask;
    end
  end

  assign free_snapshot = free_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      free_q <= RESET_FREE;
    end else begin
      free_q <= free_next;
    end
  end

  // A committed old mapping is still held when it comes back
  for (genvar i = 0; i < `RENAME_WIDTH; i++) begin : g_release_check
    a_release_not_free : assert property (@(posedge clock) disable iff (reset)
      release_valid[i] |-> !free_q[release_prf[i]])
      else $error("released register %0d is already free", release_prf[i]);
  end

endmodule

// ==== logic/rename_pkg.sv ====
/*
 * Rename stage types, the reset free bitmap and the release mask helper
 */
`include "rename_params.svh"

package rename_pkg;

  typedef logic [$clog2(`ARF_SIZE)-1:0] arf_index_t;
  typedef logic [$clog2(`PRF_SIZE)-1:0] prf_index_t;
  typedef logic [$clog2(`CP_COUNT)-1:0] cp_index_t;
  typedef logic [`PRF_SIZE-1:0]         prf_mask_t;
  typedef logic [`RENAME_WIDTH-1:0]     group_mask_t;

  // Upper half free, lower half holds the identity mapping
  localparam prf_mask_t RESET_FREE = {{(`PRF_SIZE - `ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};

  // One bit per released physical register
  function automatic prf_mask_t release_mask_of(
    input group_mask_t                    valid,
    input prf_index_t [`RENAME_WIDTH-1:0] prf
  );
    prf_mask_t mask;
    mask = '0;
    for (int i = 0; i < `RENAME_WIDTH; i++) begin
      if (valid[i]) begin
        mask[prf[i]] = 1'b1;
      end
    end
    return mask;
  endfunction

endpackage

// ==== logic/rename_params.svh ====
/*
 * Size macros of the integer rename stage
 */
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Instructions renamed per group
`define RENAME_WIDTH 2

// Integer architectural registers
`define ARF_SIZE 16

// Integer physical registers
`define PRF_SIZE 32

// Snapshot slots for branch recovery
`define CP_COUNT 4

`endif
